//--- verilog/io_cmd_pkg.sv
/*
 * Command set of the host configuration port.
 * Only 0x20, 0x27, 0x37 and 0x3A are decoded, and other codes are ignored.
 */
`default_nettype none

package io_cmd_pkg;

	typedef logic [7:0] io_cmd_t;

	localparam io_cmd_t CMD_TIMING = 8'h20;
	localparam io_cmd_t CMD_VSET   = 8'h27;
	localparam io_cmd_t CMD_HSET   = 8'h37;
	localparam io_cmd_t CMD_ARC    = 8'h3A;

	// Word slots inside the 0x20 timing block
	localparam logic [3:0] TIMING_WORD_WIDTH  = 4'd0;
	localparam logic [3:0] TIMING_WORD_HEIGHT = 4'd4;
	localparam logic [3:0] TIMING_WORDS       = 4'd8;

	// 0x37 reads a scale setting and 0x3A reads a ratio from the same word
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic        freescale;
			logic [2:0]  spare;
			logic [11:0] size;
		} scale;
		struct packed {
			logic [2:0]  spare;
			logic        xy;
			logic [11:0] value;
		} ratio;
	} io_word_t;

endpackage

`default_nettype wire

//--- verilog/video_geom_pkg.sv
/*
 * Widths and reset geometry of the output window path.
 * Sizes are 12 bits, so nothing above 4095 pixels can be expressed.
 */
`default_nettype none

package video_geom_pkg;

	localparam int DIM_W   = 12;
	localparam int RATIO_W = DIM_W + 1;

	typedef logic [DIM_W-1:0] dim_t;

	// Top bit set means the value is a pixel size, not a ratio
	typedef logic [RATIO_W-1:0] ratio_t;

	// Multiply-divide product and step counter widths
	localparam int PROD_W = 2 * DIM_W;
	localparam int STEP_W = $clog2(PROD_W);

	// 1080p output until the host sends timing
	localparam dim_t DEF_WIDTH  = 12'd1920;
	localparam dim_t DEF_HEIGHT = 12'd1080;

	// Worst case from stable settings to stable outputs
	localparam int SETTLE_CYCLES = 120;

endpackage

`default_nettype wire

//--- verilog/umuldiv.sv
/*
 * Unsigned (mul1 * mul2) / div, low 12 bits of the quotient.
 * Busy rises after start and stays high 24 clocks. Division by zero
 * gives an all-ones quotient, so callers must avoid it.
 */
`timescale 1ns/1ps
`default_nettype none

module umuldiv (
	input  wire                       clk_sys,
	input  wire                       resetd,
	input  wire                       i_start,
	input  wire video_geom_pkg::dim_t i_mul1,
	input  wire video_geom_pkg::dim_t i_mul2,
	input  wire video_geom_pkg::dim_t i_div,
	output logic                      o_busy,
	output video_geom_pkg::dim_t      o_result
);

	logic [video_geom_pkg::STEP_W-1:0] step;
	logic [video_geom_pkg::PROD_W-1:0] quo;
	logic [video_geom_pkg::DIM_W:0]    trial;
	video_geom_pkg::dim_t              rem;
	video_geom_pkg::dim_t              divisor;

	// Remainder shifted up with the next dividend bit
	assign trial    = {rem, quo[video_geom_pkg::PROD_W-1]};
	assign o_result = quo[video_geom_pkg::DIM_W-1:0];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy <= 1'b0;
			step   <= '0;
		end else if (i_start) begin
			o_busy <= 1'b1;
			step   <= '0;
		end else if (o_busy) begin
			step <= step + {{(video_geom_pkg::STEP_W-1){1'b0}}, 1'b1};
			if (int'(step) == video_geom_pkg::PROD_W - 1)
				o_busy <= 1'b0;
		end
	end

	// Product loads on start, then one restoring step per busy clock
	always_ff @(posedge clk_sys) begin
		if (i_start) begin
			quo     <= {{video_geom_pkg::DIM_W{1'b0}}, i_mul1} *
				{{video_geom_pkg::DIM_W{1'b0}}, i_mul2};
			rem     <= '0;
			divisor <= i_div;
		end else if (o_busy) begin
			if (trial >= {1'b0, divisor}) begin
				rem <= video_geom_pkg::dim_t'(trial - {1'b0, divisor});
				quo <= {quo[video_geom_pkg::PROD_W-2:0], 1'b1};
			end else begin
				rem <= trial[video_geom_pkg::DIM_W-1:0];
				quo <= {quo[video_geom_pkg::PROD_W-2:0], 1'b0};
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/io_cmd_decoder.sv
/*
 * Host command decoder. Strobes must be at least 3 clocks high and 3 low.
 * There is no readback and no wait, so words arriving faster are lost.
 * Dropping i_io_uio abandons the command in progress.
 */
`timescale 1ns/1ps
`default_nettype none

module io_cmd_decoder (
	input  wire                    clk_sys,
	input  wire                    resetd,
	input  wire                    i_io_uio,
	input  wire                    i_io_strobe,
	input  wire [15:0]             i_io_din,
	output video_geom_pkg::dim_t   o_width,
	output video_geom_pkg::dim_t   o_height,
	output video_geom_pkg::dim_t   o_vset,
	output video_geom_pkg::dim_t   o_hset,
	output logic                   o_freescale,
	output video_geom_pkg::ratio_t o_arc1x,
	output video_geom_pkg::ratio_t o_arc1y,
	output video_geom_pkg::ratio_t o_arc2x,
	output video_geom_pkg::ratio_t o_arc2y
);

	logic                 strb_s;
	logic                 strb_d;
	logic                 uio_s;
	logic                 word_stb;
	logic [15:0]          din_s;
	io_cmd_pkg::io_word_t din_w;
	logic                 has_cmd;
	io_cmd_pkg::io_cmd_t  cmd;
	logic [3:0]           cnt;

	////////////////////////////// Strobe sampling

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			strb_s   <= 1'b0;
			strb_d   <= 1'b0;
			uio_s    <= 1'b0;
			word_stb <= 1'b0;
		end else begin
			strb_s   <= i_io_strobe;
			strb_d   <= strb_s;
			uio_s    <= i_io_uio;
			word_stb <= strb_s & ~strb_d & uio_s;
		end
	end

	// Data rides along with the strobe pipeline
	always_ff @(posedge clk_sys) begin
		din_s     <= i_io_din;
		din_w.raw <= din_s;
	end

	////////////////////////////// Command and registers

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd     <= 1'b0;
			cmd         <= '0;
			cnt         <= '0;
			o_width     <= video_geom_pkg::DEF_WIDTH;
			o_height    <= video_geom_pkg::DEF_HEIGHT;
			o_vset      <= '0;
			o_hset      <= '0;
			o_freescale <= 1'b0;
			o_arc1x     <= '0;
			o_arc1y     <= '0;
			o_arc2x     <= '0;
			o_arc2y     <= '0;
		end else if (!uio_s) begin
			has_cmd <= 1'b0;
		end else if (word_stb) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= din_w.raw[7:0];
				cnt     <= '0;
			end else begin
				// Counter parks past the timing block so late words never alias
				if (cnt != io_cmd_pkg::TIMING_WORDS)
					cnt <= cnt + 4'd1;
				case (cmd)
					io_cmd_pkg::CMD_TIMING: begin
						if (cnt == io_cmd_pkg::TIMING_WORD_WIDTH)
							o_width <= din_w.raw[11:0];
						if (cnt == io_cmd_pkg::TIMING_WORD_HEIGHT)
							o_height <= din_w.raw[11:0];
					end
					io_cmd_pkg::CMD_VSET: o_vset <= din_w.raw[11:0];
					io_cmd_pkg::CMD_HSET: begin
						o_freescale <= din_w.scale.freescale;
						o_hset      <= din_w.scale.size;
					end
					io_cmd_pkg::CMD_ARC: begin
						case (cnt)
							4'd0: o_arc1x <= {din_w.ratio.xy, din_w.ratio.value};
							4'd1: o_arc1y <= {din_w.ratio.xy, din_w.ratio.value};
							4'd2: o_arc2x <= {din_w.ratio.xy, din_w.ratio.value};
							4'd3: o_arc2y <= {din_w.ratio.xy, din_w.ratio.value};
							default: ;
						endcase
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/aspect_select.sv
/*
 * Ratio select and output size clamp, one register stage.
 * A zero ary turns arx into an index: 1 and 2 pick the custom ratios.
 */
`timescale 1ns/1ps
`default_nettype none

module aspect_select (
	input  wire                         clk_sys,
	input  wire                         resetd,
	input  wire video_geom_pkg::ratio_t i_arx,
	input  wire video_geom_pkg::ratio_t i_ary,
	input  wire video_geom_pkg::dim_t   i_width,
	input  wire video_geom_pkg::dim_t   i_height,
	input  wire video_geom_pkg::dim_t   i_vset,
	input  wire video_geom_pkg::dim_t   i_hset,
	input  wire video_geom_pkg::ratio_t i_arc1x,
	input  wire video_geom_pkg::ratio_t i_arc1y,
	input  wire video_geom_pkg::ratio_t i_arc2x,
	input  wire video_geom_pkg::ratio_t i_arc2y,
	output video_geom_pkg::dim_t        o_arx,
	output video_geom_pkg::dim_t        o_ary,
	output logic                        o_xy,
	output video_geom_pkg::dim_t        o_hdmi_width,
	output video_geom_pkg::dim_t        o_hdmi_height
);

	video_geom_pkg::ratio_t pick_x;
	video_geom_pkg::ratio_t pick_y;

	always_comb begin
		pick_x = i_arx;
		pick_y = i_ary;
		if (i_ary == '0) begin
			case (i_arx)
				video_geom_pkg::ratio_t'(1): begin
					pick_x = i_arc1x;
					pick_y = i_arc1y;
				end
				video_geom_pkg::ratio_t'(2): begin
					pick_x = i_arc2x;
					pick_y = i_arc2y;
				end
				default: begin
					pick_x = '0;
					pick_y = '0;
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_arx         <= '0;
			o_ary         <= '0;
			o_xy          <= 1'b0;
			o_hdmi_width  <= video_geom_pkg::DEF_WIDTH;
			o_hdmi_height <= video_geom_pkg::DEF_HEIGHT;
		end else begin
			o_arx <= pick_x[video_geom_pkg::DIM_W-1:0];
			o_ary <= pick_y[video_geom_pkg::DIM_W-1:0];
			o_xy  <= pick_x[video_geom_pkg::RATIO_W-1] | pick_y[video_geom_pkg::RATIO_W-1];
			// Override only when it shrinks the frame
			o_hdmi_width  <= (i_hset != '0 && i_hset < i_width) ? i_hset : i_width;
			o_hdmi_height <= (i_vset != '0 && i_vset < i_height) ? i_vset : i_height;
		end
	end

endmodule

`default_nettype wire

//--- verilog/window_calc.sv
/*
 * Free-running window fit. One pass takes 57 clocks when both divides run.
 * Outputs change only at the end of a pass, and inputs are read mid-pass.
 */
`timescale 1ns/1ps
`default_nettype none

module window_calc (
	input  wire                       clk_sys,
	input  wire                       resetd,
	input  wire video_geom_pkg::dim_t i_width,
	input  wire video_geom_pkg::dim_t i_height,
	input  wire                       i_freescale,
	input  wire video_geom_pkg::dim_t i_arx,
	input  wire video_geom_pkg::dim_t i_ary,
	input  wire                       i_xy,
	input  wire video_geom_pkg::dim_t i_hdmi_width,
	input  wire video_geom_pkg::dim_t i_hdmi_height,
	output video_geom_pkg::dim_t      o_hmin,
	output video_geom_pkg::dim_t      o_hmax,
	output video_geom_pkg::dim_t      o_vmin,
	output video_geom_pkg::dim_t      o_vmax
);

	logic                 md_start;
	logic                 md_busy;
	video_geom_pkg::dim_t md_mul1;
	video_geom_pkg::dim_t md_mul2;
	video_geom_pkg::dim_t md_div;
	video_geom_pkg::dim_t md_res;
	video_geom_pkg::dim_t wcalc;
	video_geom_pkg::dim_t hcalc;
	video_geom_pkg::dim_t videow;
	video_geom_pkg::dim_t videoh;
	video_geom_pkg::dim_t h_off;
	video_geom_pkg::dim_t v_off;
	logic [2:0]           state;

	umuldiv u_muldiv (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_res)
	);

	// Left and top borders
	assign h_off = (i_width - videow) >> 1;
	assign v_off = (i_height - videoh) >> 1;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state    <= 3'd0;
			md_start <= 1'b0;
			o_hmin   <= '0;
			o_hmax   <= '0;
			o_vmin   <= '0;
			o_vmax   <= '0;
		end else begin
			md_start <= 1'b0;
			state    <= state + 3'd1;
			case (state)
				// Pick the candidate size
				3'd0: begin
					if (i_freescale || i_arx == '0 || i_ary == '0) begin
						wcalc <= i_hdmi_width;
						hcalc <= i_hdmi_height;
						state <= 3'd5;
					end else if (i_xy) begin
						wcalc <= i_arx;
						hcalc <= i_ary;
						state <= 3'd5;
					end
				end
				// Width from height
				3'd1: begin
					md_mul1  <= i_hdmi_height;
					md_mul2  <= i_arx;
					md_div   <= i_ary;
					md_start <= 1'b1;
				end
				3'd2: begin
					wcalc <= md_res;
					if (md_start || md_busy)
						state <= 3'd2;
				end
				// Height from width
				3'd3: begin
					md_mul1  <= i_hdmi_width;
					md_mul2  <= i_ary;
					md_div   <= i_arx;
					md_start <= 1'b1;
				end
				3'd4: begin
					hcalc <= md_res;
					if (md_start || md_busy)
						state <= 3'd4;
				end
				3'd5: begin
					videow <= (wcalc > i_hdmi_width) ? i_hdmi_width : wcalc;
					videoh <= (hcalc > i_hdmi_height) ? i_hdmi_height : hcalc;
				end
				3'd6: begin
					o_hmin <= h_off;
					o_hmax <= h_off + videow - video_geom_pkg::dim_t'(1);
					o_vmin <= v_off;
					o_vmax <= v_off + videoh - video_geom_pkg::dim_t'(1);
					state  <= 3'd0;
				end
				default: state <= 3'd0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/video_scale_top.sv
/*
 * Scaler geometry top. Everything runs on clk_sys.
 * Outputs settle within SETTLE_CYCLES of the last configuration change.
 */
`timescale 1ns/1ps
`default_nettype none

module video_scale_top (
	input  wire                         clk_sys,
	input  wire                         resetd,
	input  wire                         i_io_uio,
	input  wire                         i_io_strobe,
	input  wire [15:0]                  i_io_din,
	input  wire video_geom_pkg::ratio_t i_arx,
	input  wire video_geom_pkg::ratio_t i_ary,
	output wire video_geom_pkg::dim_t   o_hdmi_width,
	output wire video_geom_pkg::dim_t   o_hdmi_height,
	output wire video_geom_pkg::dim_t   o_hmin,
	output wire video_geom_pkg::dim_t   o_hmax,
	output wire video_geom_pkg::dim_t   o_vmin,
	output wire video_geom_pkg::dim_t   o_vmax
);

	wire video_geom_pkg::dim_t   cfg_width;
	wire video_geom_pkg::dim_t   cfg_height;
	wire video_geom_pkg::dim_t   cfg_vset;
	wire video_geom_pkg::dim_t   cfg_hset;
	wire                         cfg_freescale;
	wire video_geom_pkg::ratio_t cfg_arc1x;
	wire video_geom_pkg::ratio_t cfg_arc1y;
	wire video_geom_pkg::ratio_t cfg_arc2x;
	wire video_geom_pkg::ratio_t cfg_arc2y;
	wire video_geom_pkg::dim_t   sel_arx;
	wire video_geom_pkg::dim_t   sel_ary;
	wire                         sel_xy;

	io_cmd_decoder u_decoder (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_uio    (i_io_uio),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.o_width     (cfg_width),
		.o_height    (cfg_height),
		.o_vset      (cfg_vset),
		.o_hset      (cfg_hset),
		.o_freescale (cfg_freescale),
		.o_arc1x     (cfg_arc1x),
		.o_arc1y     (cfg_arc1y),
		.o_arc2x     (cfg_arc2x),
		.o_arc2y     (cfg_arc2y)
	);

	aspect_select u_aspect (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_arx         (i_arx),
		.i_ary         (i_ary),
		.i_width       (cfg_width),
		.i_height      (cfg_height),
		.i_vset        (cfg_vset),
		.i_hset        (cfg_hset),
		.i_arc1x       (cfg_arc1x),
		.i_arc1y       (cfg_arc1y),
		.i_arc2x       (cfg_arc2x),
		.i_arc2y       (cfg_arc2y),
		.o_arx         (sel_arx),
		.o_ary         (sel_ary),
		.o_xy          (sel_xy),
		.o_hdmi_width  (o_hdmi_width),
		.o_hdmi_height (o_hdmi_height)
	);

	window_calc u_window (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_width       (cfg_width),
		.i_height      (cfg_height),
		.i_freescale   (cfg_freescale),
		.i_arx         (sel_arx),
		.i_ary         (sel_ary),
		.i_xy          (sel_xy),
		.i_hdmi_width  (o_hdmi_width),
		.i_hdmi_height (o_hdmi_height),
		.o_hmin        (o_hmin),
		.o_hmax        (o_hmax),
		.o_vmin        (o_vmin),
		.o_vmax        (o_vmax)
	);

endmodule

`default_nettype wire

//--- include/tb_ref.svh
/*
 * Reference model and random source for the scaler testbench.
 * Include inside the testbench module. lfsr_state starts at 32'hf797.
 * Arithmetic keeps 12-bit wrap to match the hardware exactly.
 */
`ifndef TB_REF_SVH
`define TB_REF_SVH

// Fibonacci LFSR, taps 32 22 2 1
logic [31:0] lfsr_state = 32'hf797;

// Takes n bits, one LFSR step per bit
function automatic logic [15:0] lfsr_bits(input int unsigned n);
	logic [15:0] v;
	logic        fb;
	v = '0;
	for (int unsigned i = 0; i < n; i++) begin
		fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		v          = {v[14:0], fb};
	end
	return v;
endfunction

function automatic void ref_scale(
	input  video_geom_pkg::dim_t   width,
	input  video_geom_pkg::dim_t   height,
	input  video_geom_pkg::dim_t   vset,
	input  video_geom_pkg::dim_t   hset,
	input  logic                   freescale,
	input  video_geom_pkg::ratio_t arc1x,
	input  video_geom_pkg::ratio_t arc1y,
	input  video_geom_pkg::ratio_t arc2x,
	input  video_geom_pkg::ratio_t arc2y,
	input  video_geom_pkg::ratio_t arx,
	input  video_geom_pkg::ratio_t ary,
	output video_geom_pkg::dim_t   hdmi_w,
	output video_geom_pkg::dim_t   hdmi_h,
	output video_geom_pkg::dim_t   hmin,
	output video_geom_pkg::dim_t   hmax,
	output video_geom_pkg::dim_t   vmin,
	output video_geom_pkg::dim_t   vmax
);
	video_geom_pkg::ratio_t rx;
	video_geom_pkg::ratio_t ry;
	int                     vx;
	int                     vy;
	int                     wc;
	int                     hc;
	int                     vw;
	int                     vh;
	hdmi_w = (hset != 0 && hset < width) ? hset : width;
	hdmi_h = (vset != 0 && vset < height) ? vset : height;
	rx     = arx;
	ry     = ary;
	if (ary == 0) begin
		rx = (arx == 1) ? arc1x : (arx == 2) ? arc2x : '0;
		ry = (arx == 1) ? arc1y : (arx == 2) ? arc2y : '0;
	end
	vx = int'(rx[11:0]);
	vy = int'(ry[11:0]);
	if (freescale || vx == 0 || vy == 0) begin
		wc = int'(hdmi_w);
		hc = int'(hdmi_h);
	end else if (rx[12] || ry[12]) begin
		wc = vx;
		hc = vy;
	end else begin
		wc = (int'(hdmi_h) * vx / vy) % 4096;
		hc = (int'(hdmi_w) * vy / vx) % 4096;
	end
	vw   = (wc > int'(hdmi_w)) ? int'(hdmi_w) : wc;
	vh   = (hc > int'(hdmi_h)) ? int'(hdmi_h) : hc;
	hmin = video_geom_pkg::dim_t'(((int'(width) - vw) & 12'hfff) >> 1);
	vmin = video_geom_pkg::dim_t'(((int'(height) - vh) & 12'hfff) >> 1);
	hmax = video_geom_pkg::dim_t'((int'(hmin) + vw - 1) & 12'hfff);
	vmax = video_geom_pkg::dim_t'((int'(vmin) + vh - 1) & 12'hfff);
endfunction

`endif

//--- dv/tb_video_scale.sv
/*
 * Testbench for video_scale_top. Expected values come from ref_scale in tb_ref.svh.
 * Each check starts after the stimulus and lets the DUT settle for SETTLE_CYCLES.
 * Host words use 3 clocks high and 3 clocks low on the strobe.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_video_scale;

	logic                   clk_sys;
	logic                   resetd;
	logic                   i_io_uio;
	logic                   i_io_strobe;
	logic [15:0]            i_io_din;
	video_geom_pkg::ratio_t i_arx;
	video_geom_pkg::ratio_t i_ary;
	video_geom_pkg::dim_t   o_hdmi_width;
	video_geom_pkg::dim_t   o_hdmi_height;
	video_geom_pkg::dim_t   o_hmin;
	video_geom_pkg::dim_t   o_hmax;
	video_geom_pkg::dim_t   o_vmin;
	video_geom_pkg::dim_t   o_vmax;

	// Host side copy of the configuration
	video_geom_pkg::dim_t   m_width;
	video_geom_pkg::dim_t   m_height;
	video_geom_pkg::dim_t   m_vset;
	video_geom_pkg::dim_t   m_hset;
	logic                   m_freescale;
	video_geom_pkg::ratio_t m_arc1x;
	video_geom_pkg::ratio_t m_arc1y;
	video_geom_pkg::ratio_t m_arc2x;
	video_geom_pkg::ratio_t m_arc2y;
	video_geom_pkg::ratio_t m_arx;
	video_geom_pkg::ratio_t m_ary;

	// Expected results of the pending check
	video_geom_pkg::dim_t   exp_w;
	video_geom_pkg::dim_t   exp_h;
	video_geom_pkg::dim_t   exp_hmin;
	video_geom_pkg::dim_t   exp_hmax;
	video_geom_pkg::dim_t   exp_vmin;
	video_geom_pkg::dim_t   exp_vmax;

	string cur_test;
	logic  check_go     = 1'b0;
	logic  check_done   = 1'b0;
	int    test_errs    = 0;
	int    err_count    = 0;
	int    tests_run    = 0;
	int    tests_failed = 0;

	`include "tb_ref.svh"

	video_scale_top dut0 (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_io_uio      (i_io_uio),
		.i_io_strobe   (i_io_strobe),
		.i_io_din      (i_io_din),
		.i_arx         (i_arx),
		.i_ary         (i_ary),
		.o_hdmi_width  (o_hdmi_width),
		.o_hdmi_height (o_hdmi_height),
		.o_hmin        (o_hmin),
		.o_hmax        (o_hmax),
		.o_vmin        (o_vmin),
		.o_vmax        (o_vmax)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	////////////////////////////// Compare

	task automatic check_size(
		input video_geom_pkg::dim_t got_w,
		input video_geom_pkg::dim_t got_h,
		input video_geom_pkg::dim_t want_w,
		input video_geom_pkg::dim_t want_h
	);
		if (got_w !== want_w || got_h !== want_h) begin
			$display("ERROR %t %s: size %0dx%0d, expected %0dx%0d",
				$time, cur_test, got_w, got_h, want_w, want_h);
			test_errs++;
		end
	endtask

	task automatic check_window(
		input video_geom_pkg::dim_t got_hmin,
		input video_geom_pkg::dim_t got_hmax,
		input video_geom_pkg::dim_t got_vmin,
		input video_geom_pkg::dim_t got_vmax,
		input video_geom_pkg::dim_t want_hmin,
		input video_geom_pkg::dim_t want_hmax,
		input video_geom_pkg::dim_t want_vmin,
		input video_geom_pkg::dim_t want_vmax
	);
		if (got_hmin !== want_hmin || got_hmax !== want_hmax ||
				got_vmin !== want_vmin || got_vmax !== want_vmax) begin
			$display("ERROR %t %s: window h %0d..%0d v %0d..%0d, expected h %0d..%0d v %0d..%0d",
				$time, cur_test, got_hmin, got_hmax, got_vmin, got_vmax,
				want_hmin, want_hmax, want_vmin, want_vmax);
			test_errs++;
		end
	endtask

	// Waits out the settling time, then samples between clock edges
	initial begin
		forever begin
			@(negedge clk_sys);
			if (check_go) begin
				check_go = 1'b0;
				for (int i = 0; i < video_geom_pkg::SETTLE_CYCLES; i++)
					@(posedge clk_sys);
				@(negedge clk_sys);
				check_size(o_hdmi_width, o_hdmi_height, exp_w, exp_h);
				check_window(o_hmin, o_hmax, o_vmin, o_vmax,
					exp_hmin, exp_hmax, exp_vmin, exp_vmax);
				check_done = 1'b1;
			end
		end
	end

	task automatic run_check(input string name);
		int n;
		cur_test   = name;
		test_errs  = 0;
		check_done = 1'b0;
		check_go   = 1'b1;
		n          = 0;
		while (!check_done && n < 2 * video_geom_pkg::SETTLE_CYCLES) begin
			@(posedge clk_sys);
			n++;
		end
		tests_run++;
		if (!check_done) begin
			check_go = 1'b0;
			tests_failed++;
			err_count++;
			$display("Timeout: compare process gave no result for %s after %0d clocks", name, n);
		end else begin
			if (test_errs != 0) begin
				tests_failed++;
				err_count += test_errs;
			end
			$display("%t  %s %s", $time, name, (test_errs == 0) ? "pass" : "FAIL");
		end
	endtask

	task automatic expect_ref;
		ref_scale(m_width, m_height, m_vset, m_hset, m_freescale,
			m_arc1x, m_arc1y, m_arc2x, m_arc2y, m_arx, m_ary,
			exp_w, exp_h, exp_hmin, exp_hmax, exp_vmin, exp_vmax);
	endtask

	task automatic expect_fixed(
		input video_geom_pkg::dim_t w,
		input video_geom_pkg::dim_t h,
		input video_geom_pkg::dim_t hmin,
		input video_geom_pkg::dim_t hmax,
		input video_geom_pkg::dim_t vmin,
		input video_geom_pkg::dim_t vmax
	);
		exp_w    = w;
		exp_h    = h;
		exp_hmin = hmin;
		exp_hmax = hmax;
		exp_vmin = vmin;
		exp_vmax = vmax;
	endtask

	////////////////////////////// Host port

	task automatic send_word(input logic [15:0] w);
		@(posedge clk_sys);
		i_io_din    <= w;
		i_io_strobe <= 1'b1;
		repeat (3) @(posedge clk_sys);
		i_io_strobe <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic begin_cmd(input io_cmd_pkg::io_cmd_t c);
		@(posedge clk_sys);
		i_io_uio <= 1'b1;
		send_word({8'h00, c});
	endtask

	task automatic end_cmd;
		@(posedge clk_sys);
		i_io_uio <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic cmd_timing(input video_geom_pkg::dim_t w, input video_geom_pkg::dim_t h);
		logic [15:0] dw;
		begin_cmd(io_cmd_pkg::CMD_TIMING);
		for (int i = 0; i < int'(io_cmd_pkg::TIMING_WORDS); i++) begin
			if (i == int'(io_cmd_pkg::TIMING_WORD_WIDTH))
				dw = {4'h0, w};
			else if (i == int'(io_cmd_pkg::TIMING_WORD_HEIGHT))
				dw = {4'h0, h};
			else
				dw = lfsr_bits(16);
			send_word(dw);
		end
		end_cmd;
		m_width  = w;
		m_height = h;
	endtask

	task automatic cmd_vset(input video_geom_pkg::dim_t v);
		begin_cmd(io_cmd_pkg::CMD_VSET);
		send_word({4'h0, v});
		end_cmd;
		m_vset = v;
	endtask

	task automatic cmd_hset(input logic fs, input video_geom_pkg::dim_t h);
		begin_cmd(io_cmd_pkg::CMD_HSET);
		send_word({fs, 3'b000, h});
		end_cmd;
		m_freescale = fs;
		m_hset      = h;
	endtask

	task automatic cmd_arc(
		input video_geom_pkg::ratio_t a1x,
		input video_geom_pkg::ratio_t a1y,
		input video_geom_pkg::ratio_t a2x,
		input video_geom_pkg::ratio_t a2y
	);
		begin_cmd(io_cmd_pkg::CMD_ARC);
		send_word({3'b000, a1x});
		send_word({3'b000, a1y});
		send_word({3'b000, a2x});
		send_word({3'b000, a2y});
		end_cmd;
		m_arc1x = a1x;
		m_arc1y = a1y;
		m_arc2x = a2x;
		m_arc2y = a2y;
	endtask

	task automatic set_ratio(input video_geom_pkg::ratio_t x, input video_geom_pkg::ratio_t y);
		@(posedge clk_sys);
		i_arx <= x;
		i_ary <= y;
		m_arx = x;
		m_ary = y;
	endtask

	// Nonzero ratio term from a few LFSR bits
	function automatic video_geom_pkg::ratio_t draw_ratio(input int unsigned bits);
		return video_geom_pkg::ratio_t'(lfsr_bits(bits)) + 13'd1;
	endfunction

	////////////////////////////// Tests

	initial begin
		$timeformat(-9, 0, " ns", 12);
		resetd      <= 1'b1;
		i_io_uio    <= 1'b0;
		i_io_strobe <= 1'b0;
		i_io_din    <= 16'h0000;
		i_arx       <= '0;
		i_ary       <= '0;
		m_width     = video_geom_pkg::DEF_WIDTH;
		m_height    = video_geom_pkg::DEF_HEIGHT;
		m_vset      = '0;
		m_hset      = '0;
		m_freescale = 1'b0;
		m_arc1x     = '0;
		m_arc1y     = '0;
		m_arc2x     = '0;
		m_arc2y     = '0;
		m_arx       = '0;
		m_ary       = '0;
		repeat (2) @(posedge clk_sys);
		resetd <= 1'b0;

		// Zero ratio keeps the full frame
		expect_fixed(12'd1920, 12'd1080, 12'd0, 12'd1919, 12'd0, 12'd1079);
		run_check("reset_default");

		set_ratio(13'd4, 13'd3);
		expect_fixed(12'd1920, 12'd1080, 12'd240, 12'd1679, 12'd0, 12'd1079);
		run_check("core_4x3");
		for (int k = 0; k < 5; k++) begin
			set_ratio(draw_ratio(4), draw_ratio(4));
			expect_ref;
			run_check($sformatf("core_rand_%0d", k));
		end

		// Custom ratios picked by index when ary is zero
		cmd_arc(draw_ratio(5), draw_ratio(5), draw_ratio(5), draw_ratio(5));
		set_ratio(13'd1, 13'd0);
		expect_ref;
		run_check("custom_1");
		set_ratio(13'd2, 13'd0);
		expect_ref;
		run_check("custom_2");
		set_ratio(13'd3, 13'd0);
		expect_ref;
		run_check("custom_none");

		// Pixel size instead of ratio
		set_ratio({1'b1, 12'd1280}, {1'b0, 12'd720});
		expect_ref;
		run_check("xy_1280x720");
		set_ratio({1'b1, 12'd2500}, {1'b1, 12'd900});
		expect_ref;
		run_check("xy_clamped");

		cmd_timing(12'd1280, 12'd720);
		set_ratio(13'd4, 13'd3);
		expect_ref;
		run_check("timing_1280x720");
		cmd_vset(12'd600);
		cmd_hset(1'b0, 12'd1000);
		expect_ref;
		run_check("vset_hset");
		cmd_hset(1'b1, 12'd1000);
		expect_ref;
		run_check("freescale");

		// Aborted commands, next word after uio rises is a new command
		cmd_hset(1'b0, 12'd0);
		set_ratio(13'd1, 13'd0);
		begin_cmd(io_cmd_pkg::CMD_ARC);
		end_cmd;
		cmd_vset(12'd500);
		begin_cmd(io_cmd_pkg::CMD_HSET);
		end_cmd;
		begin_cmd(8'h55);
		send_word(16'h0280);
		end_cmd;
		expect_ref;
		run_check("uio_abort");

		$display("Checks: %0d run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
		if (err_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
verilog/io_cmd_pkg.sv
verilog/video_geom_pkg.sv
verilog/umuldiv.sv
verilog/io_cmd_decoder.sv
verilog/aspect_select.sv
verilog/window_calc.sv
verilog/video_scale_top.sv
dv/tb_video_scale.sv

//--- Makefile
# Verilator flow for the scaler geometry testbench
TB := tb_video_scale

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module video_scale_top

sim:
	verilator --binary --timing -f build.f --top-module $(TB) -o sim_$(TB)
	./obj_dir/sim_$(TB) | tee sim.log
	grep -qx "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
